// ==== Bender.yml ====
package:
  name: exu

sources:
  - files:
      - hw/exu_pkg.sv
      - hw/exu_op_decode.sv
      - hw/exu_alu.sv
      - hw/exu_lsu_reg.sv
      - hw/exu.sv
  - target: test
    files:
      - dv/exu_checker.sv
      - dv/exu_tb.sv

// ==== dv/exu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_checker (
    input logic                            clk,
    input logic                            rst,
    input logic                            lsu_rdy,
    input logic                            br_vld,
    input logic                            flush,
    input logic                            lsu_vld,
    input logic                            lsu_wb_vld,
    input logic [4:0]                      lsu_rd,
    input logic [exu_pkg::XLEN-1:0]        lsu_wb_data,
    input logic [exu_pkg::XLEN-1:0]        lsu_src2,
    input logic                            lsu_ld,
    input logic                            lsu_st,
    input logic [1:0]                      lsu_size,
    input logic                            lsu_unsigned,
    input logic                            lsu_iram,
    input logic                            lsu_oram,
    input logic                            lsu_wram,
    input logic [exu_pkg::SRAM_ADDR_W-1:0] lsu_sram_addr
);

    logic [2*exu_pkg::XLEN+exu_pkg::SRAM_ADDR_W+13:0] lsu_bundle;

    assign lsu_bundle = {lsu_wb_vld, lsu_rd, lsu_wb_data, lsu_src2, lsu_ld, lsu_st,
                         lsu_size, lsu_unsigned, lsu_iram, lsu_oram, lsu_wram,
                         lsu_sram_addr};

    // request held under back-pressure
    a_lsu_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_vld && !lsu_rdy |=> lsu_vld && $stable(lsu_bundle))
        else $error("lsu request changed while stalled");

    a_br_once: assert property (@(posedge clk) disable iff (rst) br_vld |=> !br_vld)
        else $error("br_vld high for two cycles");

    a_flush_eq: assert property (@(posedge clk) disable iff (rst) flush == br_vld)
        else $error("flush differs from br_vld");

    a_rst_idle: assert property (@(posedge clk) rst |=> !lsu_vld && !br_vld)
        else $error("lsu_vld or br_vld high after reset");

endmodule

bind exu exu_checker u_checker (.*);

`default_nettype wire

// ==== dv/exu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_tb;

    localparam int PC_W        = 12;
    localparam int CLK_NS      = 8;
    localparam int RST_CYCLES  = 10;
    localparam int N_INSTR     = 2000;
    localparam int WATCHDOG_NS = (RST_CYCLES + 20 * N_INSTR) * CLK_NS;

    typedef struct packed {
        logic [exu_pkg::XLEN-1:0]        wb;
        logic                            wr;
        logic                            taken;
        logic [exu_pkg::XLEN-1:0]        target;
        logic                            ld;
        logic                            st;
        logic                            iram;
        logic                            oram;
        logic                            wram;
        logic [exu_pkg::SRAM_ADDR_W-1:0] sram_addr;
        logic [1:0]                      size;
        logic                            uns;
        logic                            rd_vld;
        logic [4:0]                      rd;
        logic [exu_pkg::XLEN-1:0]        src2;
    } exp_t;

    logic                            clk;
    logic                            rst;
    logic                            in_vld;
    logic [exu_pkg::OP_W-1:0]        op;
    logic [exu_pkg::XLEN-1:0]        src1;
    logic [exu_pkg::XLEN-1:0]        src2;
    logic [exu_pkg::XLEN-1:0]        imm;
    logic [exu_pkg::XLEN-1:0]        pc;
    logic                            rd_vld;
    logic [4:0]                      rd;
    logic                            lsu_rdy;
    logic                            in_rdy;
    logic                            flush;
    logic                            wb_vld;
    logic [4:0]                      wb_rd;
    logic [exu_pkg::XLEN-1:0]        wb_data;
    logic                            ld_vld;
    logic                            br_vld;
    logic [PC_W-1:0]                 br_addr;
    logic                            lsu_vld;
    logic                            lsu_wb_vld;
    logic [4:0]                      lsu_rd;
    logic [exu_pkg::XLEN-1:0]        lsu_wb_data;
    logic [exu_pkg::XLEN-1:0]        lsu_src2;
    logic                            lsu_ld;
    logic                            lsu_st;
    logic [1:0]                      lsu_size;
    logic                            lsu_unsigned;
    logic                            lsu_iram;
    logic                            lsu_oram;
    logic                            lsu_wram;
    logic [exu_pkg::SRAM_ADDR_W-1:0] lsu_sram_addr;

    integer          seed;
    exp_t            q[$];
    int              n_acc       = 0;
    int              n_cons      = 0;
    logic            exp_br      = 1'b0;
    logic [PC_W-1:0] exp_br_addr = '0;
    logic            last_acc    = 1'b0;
    logic            last_flush  = 1'b0;

    exu #(
        .PC_W (PC_W)
    ) u_exu (
        .clk           (clk),
        .rst           (rst),
        .in_vld        (in_vld),
        .op            (op),
        .src1          (src1),
        .src2          (src2),
        .imm           (imm),
        .pc            (pc),
        .rd_vld        (rd_vld),
        .rd            (rd),
        .lsu_rdy       (lsu_rdy),
        .in_rdy        (in_rdy),
        .flush         (flush),
        .wb_vld        (wb_vld),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .ld_vld        (ld_vld),
        .br_vld        (br_vld),
        .br_addr       (br_addr),
        .lsu_vld       (lsu_vld),
        .lsu_wb_vld    (lsu_wb_vld),
        .lsu_rd        (lsu_rd),
        .lsu_wb_data   (lsu_wb_data),
        .lsu_src2      (lsu_src2),
        .lsu_ld        (lsu_ld),
        .lsu_st        (lsu_st),
        .lsu_size      (lsu_size),
        .lsu_unsigned  (lsu_unsigned),
        .lsu_iram      (lsu_iram),
        .lsu_oram      (lsu_oram),
        .lsu_wram      (lsu_wram),
        .lsu_sram_addr (lsu_sram_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic exp_t exu_ref(input logic [4:0] f_op, input logic [31:0] s1,
                                     input logic [31:0] s2, input logic [31:0] f_imm,
                                     input logic [31:0] f_pc);
        exp_t        r;
        logic [31:0] addr;
        logic [1:0]  bank;
        r = '0;
        case (f_op)
            exu_pkg::OP_ADD:   r.wb = s1 + s2;
            exu_pkg::OP_SUB:   r.wb = s1 - s2;
            exu_pkg::OP_SLT:   r.wb = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
            exu_pkg::OP_SLTU:  r.wb = (s1 < s2) ? 32'd1 : 32'd0;
            exu_pkg::OP_XOR:   r.wb = s1 ^ s2;
            exu_pkg::OP_OR:    r.wb = s1 | s2;
            exu_pkg::OP_AND:   r.wb = s1 & s2;
            exu_pkg::OP_SLL:   r.wb = s1 << s2[4:0];
            exu_pkg::OP_SRL:   r.wb = s1 >> s2[4:0];
            exu_pkg::OP_SRA:   r.wb = $unsigned($signed(s1) >>> s2[4:0]);
            exu_pkg::OP_LUI:   r.wb = s2;
            exu_pkg::OP_AUIPC: r.wb = f_pc + s2;
            exu_pkg::OP_BEQ:   r.taken = (s1 == s2);
            exu_pkg::OP_BNE:   r.taken = (s1 != s2);
            exu_pkg::OP_BLT:   r.taken = ($signed(s1) < $signed(s2));
            exu_pkg::OP_BGE:   r.taken = ($signed(s1) >= $signed(s2));
            exu_pkg::OP_BLTU:  r.taken = (s1 < s2);
            exu_pkg::OP_BGEU:  r.taken = (s1 >= s2);
            default: ;
        endcase
        if (f_op == exu_pkg::OP_JAL || f_op == exu_pkg::OP_JALR) begin
            r.wb    = f_pc + 32'd4;
            r.taken = 1'b1;
        end
        if (f_op == exu_pkg::OP_JAL) begin
            r.target = f_pc + s2;
        end else if (f_op == exu_pkg::OP_JALR) begin
            r.target = s1 + s2;
        end else begin
            r.target = f_pc + f_imm;
        end
        r.wr = (f_op >= exu_pkg::OP_ADD && f_op <= exu_pkg::OP_JALR)
            || (f_op >= exu_pkg::OP_LB && f_op <= exu_pkg::OP_LHU);
        r.ld  = (f_op >= exu_pkg::OP_LB && f_op <= exu_pkg::OP_LHU);
        r.st  = (f_op >= exu_pkg::OP_SB && f_op <= exu_pkg::OP_SW);
        r.uns = (f_op == exu_pkg::OP_LBU || f_op == exu_pkg::OP_LHU);
        case (f_op)
            exu_pkg::OP_LB, exu_pkg::OP_LBU, exu_pkg::OP_SB: r.size = exu_pkg::SIZE_B;
            exu_pkg::OP_LH, exu_pkg::OP_LHU, exu_pkg::OP_SH: r.size = exu_pkg::SIZE_H;
            default:                                         r.size = exu_pkg::SIZE_W;
        endcase
        // bank sits just above the local address
        addr        = r.st ? s1 + f_imm : s1 + s2;
        bank        = addr[exu_pkg::SRAM_ADDR_W +: exu_pkg::BANK_W];
        r.sram_addr = addr[exu_pkg::SRAM_ADDR_W-1:0];
        r.iram      = (r.ld || r.st) && bank == exu_pkg::BANK_IRAM;
        r.oram      = (r.ld || r.st) && bank == exu_pkg::BANK_ORAM;
        r.wram      = r.ld && bank == exu_pkg::BANK_WRAM;
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic new_instr;
        exp_t        r;
        logic [31:0] rnd;
        rnd  = $random(seed);
        op   = rnd[4:0];
        src1 = $random(seed);
        src2 = $random(seed);
        imm  = $random(seed);
        pc   = $random(seed);
        pc[1:0] = 2'b00;
        // equal and sign-flipped operands for the compares
        if (rnd[6:5] == 2'd0) begin
            src2 = src1;
        end else if (rnd[6:5] == 2'd1) begin
            src2 = src1 ^ 32'h8000_0000;
        end
        rd     = rnd[11:7];
        r      = exu_ref(op, src1, src2, imm, pc);
        rd_vld = r.wr && (rnd[14:12] != 3'd0);
        in_vld = (rnd[17:15] != 3'd0);
    endtask

    always @(negedge clk) begin
        exp_t r;
        exp_t it;
        logic acc;
        if (rst) begin
            check_val("br_vld", br_vld, 0);
            check_val("flush", flush, 0);
            check_val("lsu_vld", lsu_vld, 0);
            check_val("lsu_wb_vld", lsu_wb_vld, 0);
            check_val("in_rdy", in_rdy, lsu_rdy);
            q.delete();
            exp_br     = 1'b0;
            last_acc   = 1'b0;
            last_flush = 1'b0;
        end else begin
            check_val("in_rdy", in_rdy, lsu_rdy);
            check_val("br_vld", br_vld, exp_br);
            check_val("flush", flush, exp_br);
            if (exp_br) begin
                check_val("br_addr", br_addr, exp_br_addr);
            end
            check_val("lsu_vld", lsu_vld, q.size() != 0);
            if (lsu_vld && lsu_rdy) begin
                it = q.pop_front();
                n_cons++;
                check_val("lsu_ld", lsu_ld, it.ld);
                check_val("lsu_st", lsu_st, it.st);
                check_val("lsu_iram", lsu_iram, it.iram);
                check_val("lsu_oram", lsu_oram, it.oram);
                check_val("lsu_wram", lsu_wram, it.wram);
                check_val("lsu_wb_vld", lsu_wb_vld, it.rd_vld);
                if (it.rd_vld) begin
                    check_val("lsu_rd", lsu_rd, it.rd);
                end
                if (it.rd_vld && !it.ld) begin
                    check_val("lsu_wb_data", lsu_wb_data, it.wb);
                end
                if (it.ld || it.st) begin
                    check_val("lsu_sram_addr", lsu_sram_addr, it.sram_addr);
                    check_val("lsu_size", lsu_size, it.size);
                    check_val("lsu_unsigned", lsu_unsigned, it.uns);
                    check_val("lsu_src2", lsu_src2, it.src2);
                end
            end
            r        = exu_ref(op, src1, src2, imm, pc);
            r.rd_vld = rd_vld;
            r.rd     = rd;
            r.src2   = src2;
            // nothing is taken in the redirect cycle
            acc = in_vld && lsu_rdy && !exp_br;
            check_val("wb_vld", wb_vld, acc && rd_vld);
            if (wb_vld && !r.ld) begin
                check_val("wb_data", wb_data, r.wb);
                check_val("wb_rd", wb_rd, rd);
            end
            check_val("ld_vld", ld_vld, acc && r.ld);
            last_flush  = exp_br;
            last_acc    = acc;
            exp_br      = acc && r.taken;
            exp_br_addr = r.target[PC_W-1:0];
            if (acc) begin
                q.push_back(r);
                n_acc++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d accepted instructions", n_acc);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] rnd;
        seed    = 85320;
        rst     = 1'b1;
        in_vld  = 1'b0;
        op      = '0;
        src1    = '0;
        src2    = '0;
        imm     = '0;
        pc      = '0;
        rd_vld  = 1'b0;
        rd      = '0;
        lsu_rdy = 1'b0;
        repeat (RST_CYCLES) begin
            @(posedge clk);
            #1;
            rnd     = $random(seed);
            lsu_rdy = rnd[0];
        end
        rst = 1'b0;
        while (n_acc < N_INSTR) begin
            @(posedge clk);
            #1;
            rnd     = $random(seed);
            lsu_rdy = (rnd[1:0] != 2'd0);
            // hold the instruction until it is taken or flushed
            if (!in_vld || last_acc || last_flush) begin
                new_instr();
            end
        end
        @(posedge clk);
        #1;
        in_vld  = 1'b0;
        lsu_rdy = 1'b1;
        repeat (4) @(posedge clk);
        if (n_cons == n_acc && q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("requests not drained, %0d accepted and %0d consumed", n_acc, n_cons);
            $display("TEST FAILED");
            $fatal(1, "request queue not drained");
        end
    end

endmodule

`default_nettype wire

// ==== hw/exu.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu #(
    parameter int PC_W = 12
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_vld,
    input  logic [exu_pkg::OP_W-1:0]        op,
    input  logic [exu_pkg::XLEN-1:0]        src1,
    input  logic [exu_pkg::XLEN-1:0]        src2,
    input  logic [exu_pkg::XLEN-1:0]        imm,
    input  logic [exu_pkg::XLEN-1:0]        pc,
    input  logic                            rd_vld,
    input  logic [4:0]                      rd,
    input  logic                            lsu_rdy,
    output logic                            in_rdy,
    output logic                            flush,
    output logic                            wb_vld,
    output logic [4:0]                      wb_rd,
    output logic [exu_pkg::XLEN-1:0]        wb_data,
    output logic                            ld_vld,
    output logic                            br_vld,
    output logic [PC_W-1:0]                 br_addr,
    output logic                            lsu_vld,
    output logic                            lsu_wb_vld,
    output logic [4:0]                      lsu_rd,
    output logic [exu_pkg::XLEN-1:0]        lsu_wb_data,
    output logic [exu_pkg::XLEN-1:0]        lsu_src2,
    output logic                            lsu_ld,
    output logic                            lsu_st,
    output logic [1:0]                      lsu_size,
    output logic                            lsu_unsigned,
    output logic                            lsu_iram,
    output logic                            lsu_oram,
    output logic                            lsu_wram,
    output logic [exu_pkg::SRAM_ADDR_W-1:0] lsu_sram_addr
);

    logic [3:0]               alu_fn;
    logic                     use_pc_link;
    logic [2:0]               br_cond;
    logic                     is_branch;
    logic                     is_jal;
    logic                     is_jalr;
    logic                     is_load;
    logic                     is_store;
    logic [1:0]               mem_size;
    logic                     mem_unsigned;
    logic [exu_pkg::XLEN-1:0] result;
    logic                     taken;
    logic [exu_pkg::XLEN-1:0] target;
    exu_pkg::eff_addr_u       eff_addr;

    exu_op_decode u_op_decode (
        .op           (op),
        .alu_fn       (alu_fn),
        .use_pc_link  (use_pc_link),
        .br_cond      (br_cond),
        .is_branch    (is_branch),
        .is_jal       (is_jal),
        .is_jalr      (is_jalr),
        .is_load      (is_load),
        .is_store     (is_store),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned)
    );

    exu_alu u_alu (
        .alu_fn      (alu_fn),
        .use_pc_link (use_pc_link),
        .br_cond     (br_cond),
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .is_store    (is_store),
        .src1        (src1),
        .src2        (src2),
        .imm         (imm),
        .pc          (pc),
        .result      (result),
        .taken       (taken),
        .target      (target),
        .eff_addr    (eff_addr)
    );

    exu_lsu_reg #(
        .PC_W (PC_W)
    ) u_lsu_reg (
        .clk           (clk),
        .rst           (rst),
        .in_vld        (in_vld),
        .rd_vld        (rd_vld),
        .rd            (rd),
        .lsu_rdy       (lsu_rdy),
        .is_load       (is_load),
        .is_store      (is_store),
        .mem_size      (mem_size),
        .mem_unsigned  (mem_unsigned),
        .result        (result),
        .taken         (taken),
        .target        (target),
        .eff_addr      (eff_addr),
        .src2          (src2),
        .in_rdy        (in_rdy),
        .flush         (flush),
        .br_vld        (br_vld),
        .br_addr       (br_addr),
        .wb_vld        (wb_vld),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .ld_vld        (ld_vld),
        .lsu_vld       (lsu_vld),
        .lsu_wb_vld    (lsu_wb_vld),
        .lsu_rd        (lsu_rd),
        .lsu_wb_data   (lsu_wb_data),
        .lsu_src2      (lsu_src2),
        .lsu_ld        (lsu_ld),
        .lsu_st        (lsu_st),
        .lsu_size      (lsu_size),
        .lsu_unsigned  (lsu_unsigned),
        .lsu_iram      (lsu_iram),
        .lsu_oram      (lsu_oram),
        .lsu_wram      (lsu_wram),
        .lsu_sram_addr (lsu_sram_addr)
    );

endmodule

`default_nettype wire

// ==== hw/exu_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_alu (
    input  logic [3:0]                alu_fn,
    input  logic                      use_pc_link,
    input  logic [2:0]                br_cond,
    input  logic                      is_branch,
    input  logic                      is_jal,
    input  logic                      is_jalr,
    input  logic                      is_store,
    input  logic [exu_pkg::XLEN-1:0]  src1,
    input  logic [exu_pkg::XLEN-1:0]  src2,
    input  logic [exu_pkg::XLEN-1:0]  imm,
    input  logic [exu_pkg::XLEN-1:0]  pc,
    output logic [exu_pkg::XLEN-1:0]  result,
    output logic                      taken,
    output logic [exu_pkg::XLEN-1:0]  target,
    output exu_pkg::eff_addr_u        eff_addr
);

    localparam logic [exu_pkg::XLEN-1:0] PC_STEP = 4;

    logic [exu_pkg::XLEN-1:0] sum;
    logic [exu_pkg::XLEN-1:0] diff;
    logic [exu_pkg::XLEN-1:0] pc_src2;
    logic [exu_pkg::XLEN-1:0] pc_imm;
    logic [exu_pkg::XLEN-1:0] src1_imm;
    logic [4:0]               shamt;
    logic                     lt_s;
    logic                     lt_u;
    logic                     eq;
    logic                     cond;

    assign sum      = src1 + src2;
    assign diff     = src1 - src2;
    assign pc_src2  = pc + src2;
    assign pc_imm   = pc + imm;
    assign src1_imm = src1 + imm;
    assign shamt    = src2[4:0];

    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;
    assign eq   = src1 == src2;

    always_comb begin
        case (alu_fn)
            exu_pkg::ALU_ADD:   result = sum;
            exu_pkg::ALU_SUB:   result = diff;
            exu_pkg::ALU_SLT:   result = {{(exu_pkg::XLEN-1){1'b0}}, lt_s};
            exu_pkg::ALU_SLTU:  result = {{(exu_pkg::XLEN-1){1'b0}}, lt_u};
            exu_pkg::ALU_XOR:   result = src1 ^ src2;
            exu_pkg::ALU_OR:    result = src1 | src2;
            exu_pkg::ALU_AND:   result = src1 & src2;
            exu_pkg::ALU_SLL:   result = src1 << shamt;
            exu_pkg::ALU_SRL:   result = src1 >> shamt;
            exu_pkg::ALU_SRA:   result = $unsigned($signed(src1) >>> shamt);
            exu_pkg::ALU_LUI:   result = src2;
            exu_pkg::ALU_AUIPC: result = pc_src2;
            default:            result = sum;
        endcase
        // link address overrides the function select
        if (use_pc_link) begin
            result = pc + PC_STEP;
        end
    end

    always_comb begin
        case (br_cond)
            exu_pkg::BR_EQ:  cond = eq;
            exu_pkg::BR_NE:  cond = !eq;
            exu_pkg::BR_LT:  cond = lt_s;
            exu_pkg::BR_GE:  cond = !lt_s;
            exu_pkg::BR_LTU: cond = lt_u;
            exu_pkg::BR_GEU: cond = !lt_u;
            default:         cond = 1'b0;
        endcase
    end

    assign taken = (is_branch & cond) | is_jal | is_jalr;

    always_comb begin
        if (is_jal) begin
            target = pc_src2;
        end else if (is_jalr) begin
            target = sum;
        end else begin
            target = pc_imm;
        end
    end

    // stores take the immediate, loads get it through src2
    assign eff_addr.raw = is_store ? src1_imm : sum;

endmodule

`default_nettype wire

// ==== hw/exu_lsu_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_lsu_reg #(
    parameter int PC_W = 12
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_vld,
    input  logic                            rd_vld,
    input  logic [4:0]                      rd,
    input  logic                            lsu_rdy,
    input  logic                            is_load,
    input  logic                            is_store,
    input  logic [1:0]                      mem_size,
    input  logic                            mem_unsigned,
    input  logic [exu_pkg::XLEN-1:0]        result,
    input  logic                            taken,
    input  logic [exu_pkg::XLEN-1:0]        target,
    input  exu_pkg::eff_addr_u              eff_addr,
    input  logic [exu_pkg::XLEN-1:0]        src2,
    output logic                            in_rdy,
    output logic                            flush,
    output logic                            br_vld,
    output logic [PC_W-1:0]                 br_addr,
    output logic                            wb_vld,
    output logic [4:0]                      wb_rd,
    output logic [exu_pkg::XLEN-1:0]        wb_data,
    output logic                            ld_vld,
    output logic                            lsu_vld,
    output logic                            lsu_wb_vld,
    output logic [4:0]                      lsu_rd,
    output logic [exu_pkg::XLEN-1:0]        lsu_wb_data,
    output logic [exu_pkg::XLEN-1:0]        lsu_src2,
    output logic                            lsu_ld,
    output logic                            lsu_st,
    output logic [1:0]                      lsu_size,
    output logic                            lsu_unsigned,
    output logic                            lsu_iram,
    output logic                            lsu_oram,
    output logic                            lsu_wram,
    output logic [exu_pkg::SRAM_ADDR_W-1:0] lsu_sram_addr
);

    logic accept;
    logic mem_op;

    // the slot after a taken branch is dropped by decode
    assign accept = in_vld & lsu_rdy & ~br_vld;
    assign mem_op = is_load | is_store;

    assign in_rdy  = lsu_rdy;
    assign flush   = br_vld;
    assign wb_vld  = accept & rd_vld;
    assign wb_rd   = rd;
    assign wb_data = result;
    assign ld_vld  = accept & is_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            br_vld     <= 1'b0;
            lsu_vld    <= 1'b0;
            lsu_wb_vld <= 1'b0;
        end else begin
            br_vld <= accept & taken;
            if (accept) begin
                lsu_vld    <= 1'b1;
                lsu_wb_vld <= rd_vld;
            end else if (lsu_rdy) begin
                lsu_vld    <= 1'b0;
                lsu_wb_vld <= 1'b0;
            end
        end
    end

    // only written on accept, so they hold under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            br_addr       <= target[PC_W-1:0];
            lsu_rd        <= rd;
            lsu_wb_data   <= result;
            lsu_src2      <= src2;
            lsu_ld        <= is_load;
            lsu_st        <= is_store;
            lsu_size      <= mem_size;
            lsu_unsigned  <= mem_unsigned;
            lsu_iram      <= mem_op & (eff_addr.f.bank == exu_pkg::BANK_IRAM);
            lsu_oram      <= mem_op & (eff_addr.f.bank == exu_pkg::BANK_ORAM);
            lsu_wram      <= is_load & (eff_addr.f.bank == exu_pkg::BANK_WRAM);
            lsu_sram_addr <= eff_addr.f.local_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/exu_op_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_op_decode (
    input  logic [exu_pkg::OP_W-1:0] op,
    output logic [3:0]               alu_fn,
    output logic                     use_pc_link,
    output logic [2:0]               br_cond,
    output logic                     is_branch,
    output logic                     is_jal,
    output logic                     is_jalr,
    output logic                     is_load,
    output logic                     is_store,
    output logic [1:0]               mem_size,
    output logic                     mem_unsigned
);

    always_comb begin
        alu_fn       = exu_pkg::ALU_ADD;
        use_pc_link  = 1'b0;
        br_cond      = exu_pkg::BR_EQ;
        is_branch    = 1'b0;
        is_jal       = 1'b0;
        is_jalr      = 1'b0;
        is_load      = 1'b0;
        is_store     = 1'b0;
        mem_size     = exu_pkg::SIZE_W;
        mem_unsigned = 1'b0;
        case (op)
            exu_pkg::OP_ADD:   alu_fn = exu_pkg::ALU_ADD;
            exu_pkg::OP_SUB:   alu_fn = exu_pkg::ALU_SUB;
            exu_pkg::OP_SLT:   alu_fn = exu_pkg::ALU_SLT;
            exu_pkg::OP_SLTU:  alu_fn = exu_pkg::ALU_SLTU;
            exu_pkg::OP_XOR:   alu_fn = exu_pkg::ALU_XOR;
            exu_pkg::OP_OR:    alu_fn = exu_pkg::ALU_OR;
            exu_pkg::OP_AND:   alu_fn = exu_pkg::ALU_AND;
            exu_pkg::OP_SLL:   alu_fn = exu_pkg::ALU_SLL;
            exu_pkg::OP_SRL:   alu_fn = exu_pkg::ALU_SRL;
            exu_pkg::OP_SRA:   alu_fn = exu_pkg::ALU_SRA;
            exu_pkg::OP_LUI:   alu_fn = exu_pkg::ALU_LUI;
            exu_pkg::OP_AUIPC: alu_fn = exu_pkg::ALU_AUIPC;
            exu_pkg::OP_JAL: begin
                use_pc_link = 1'b1;
                is_jal      = 1'b1;
            end
            exu_pkg::OP_JALR: begin
                use_pc_link = 1'b1;
                is_jalr     = 1'b1;
            end
            exu_pkg::OP_BEQ,
            exu_pkg::OP_BNE,
            exu_pkg::OP_BLT,
            exu_pkg::OP_BGE,
            exu_pkg::OP_BLTU,
            exu_pkg::OP_BGEU: begin
                is_branch = 1'b1;
                br_cond   = 3'(op - exu_pkg::OP_BEQ);
            end
            exu_pkg::OP_LB,
            exu_pkg::OP_LBU: begin
                is_load      = 1'b1;
                mem_size     = exu_pkg::SIZE_B;
                mem_unsigned = (op == exu_pkg::OP_LBU);
            end
            exu_pkg::OP_LH,
            exu_pkg::OP_LHU: begin
                is_load      = 1'b1;
                mem_size     = exu_pkg::SIZE_H;
                mem_unsigned = (op == exu_pkg::OP_LHU);
            end
            exu_pkg::OP_LW:    is_load = 1'b1;
            exu_pkg::OP_SB: begin
                is_store = 1'b1;
                mem_size = exu_pkg::SIZE_B;
            end
            exu_pkg::OP_SH: begin
                is_store = 1'b1;
                mem_size = exu_pkg::SIZE_H;
            end
            exu_pkg::OP_SW:    is_store = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    localparam int XLEN = 32;
    localparam int OP_W = 5;

    // opcode codes, all others decode as no-op
    localparam logic [OP_W-1:0] OP_ADD   = 5'd1;
    localparam logic [OP_W-1:0] OP_SUB   = 5'd2;
    localparam logic [OP_W-1:0] OP_SLT   = 5'd3;
    localparam logic [OP_W-1:0] OP_SLTU  = 5'd4;
    localparam logic [OP_W-1:0] OP_XOR   = 5'd5;
    localparam logic [OP_W-1:0] OP_OR    = 5'd6;
    localparam logic [OP_W-1:0] OP_AND   = 5'd7;
    localparam logic [OP_W-1:0] OP_SLL   = 5'd8;
    localparam logic [OP_W-1:0] OP_SRL   = 5'd9;
    localparam logic [OP_W-1:0] OP_SRA   = 5'd10;
    localparam logic [OP_W-1:0] OP_LUI   = 5'd11;
    localparam logic [OP_W-1:0] OP_AUIPC = 5'd12;
    localparam logic [OP_W-1:0] OP_JAL   = 5'd13;
    localparam logic [OP_W-1:0] OP_JALR  = 5'd14;
    localparam logic [OP_W-1:0] OP_BEQ   = 5'd15;
    localparam logic [OP_W-1:0] OP_BNE   = 5'd16;
    localparam logic [OP_W-1:0] OP_BLT   = 5'd17;
    localparam logic [OP_W-1:0] OP_BGE   = 5'd18;
    localparam logic [OP_W-1:0] OP_BLTU  = 5'd19;
    localparam logic [OP_W-1:0] OP_BGEU  = 5'd20;
    localparam logic [OP_W-1:0] OP_LB    = 5'd21;
    localparam logic [OP_W-1:0] OP_LH    = 5'd22;
    localparam logic [OP_W-1:0] OP_LW    = 5'd23;
    localparam logic [OP_W-1:0] OP_LBU   = 5'd24;
    localparam logic [OP_W-1:0] OP_LHU   = 5'd25;
    localparam logic [OP_W-1:0] OP_SB    = 5'd26;
    localparam logic [OP_W-1:0] OP_SH    = 5'd27;
    localparam logic [OP_W-1:0] OP_SW    = 5'd28;

    // alu function select
    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_SUB   = 4'd1;
    localparam logic [3:0] ALU_SLT   = 4'd2;
    localparam logic [3:0] ALU_SLTU  = 4'd3;
    localparam logic [3:0] ALU_XOR   = 4'd4;
    localparam logic [3:0] ALU_OR    = 4'd5;
    localparam logic [3:0] ALU_AND   = 4'd6;
    localparam logic [3:0] ALU_SLL   = 4'd7;
    localparam logic [3:0] ALU_SRL   = 4'd8;
    localparam logic [3:0] ALU_SRA   = 4'd9;
    localparam logic [3:0] ALU_LUI   = 4'd10;
    localparam logic [3:0] ALU_AUIPC = 4'd11;

    // branch condition kind
    localparam logic [2:0] BR_EQ  = 3'd0;
    localparam logic [2:0] BR_NE  = 3'd1;
    localparam logic [2:0] BR_LT  = 3'd2;
    localparam logic [2:0] BR_GE  = 3'd3;
    localparam logic [2:0] BR_LTU = 3'd4;
    localparam logic [2:0] BR_GEU = 3'd5;

    localparam int SRAM_ADDR_W = 12;
    localparam int BANK_W      = 2;

    // code 3 selects no bank
    localparam logic [BANK_W-1:0] BANK_IRAM = 2'd0;
    localparam logic [BANK_W-1:0] BANK_ORAM = 2'd1;
    localparam logic [BANK_W-1:0] BANK_WRAM = 2'd2;

    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;

    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [XLEN-BANK_W-SRAM_ADDR_W-1:0] upper;
            logic [BANK_W-1:0]                  bank;
            logic [SRAM_ADDR_W-1:0]             local_addr;
        } f;
    } eff_addr_u;

endpackage

`default_nettype wire

// ==== list.f ====
hw/exu_pkg.sv
hw/exu_op_decode.sv
hw/exu_alu.sv
hw/exu_lsu_reg.sv
hw/exu.sv
dv/exu_checker.sv
dv/exu_tb.sv
